//--- src/fixed_to_float.sv
// Three register stages gated by advance; no denormal, infinity or NaN outputs are produced
`timescale 1ns/10ps

module fixed_to_float #(
    parameter int input_width = 32
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  advance,
    input  logic                                  in_valid,
    input  logic [input_width-1:0]                in_data,
    input  fp_convert_pkg::fixed_format_t         in_format,
    output logic                                  out_valid,
    output logic [fp_convert_pkg::float_width-1:0] out_data
);

    localparam int index_width = $clog2(input_width);
    localparam int man_width = fp_convert_pkg::mantissa_width;
    localparam int exp_width = fp_convert_pkg::exponent_width;
    localparam int shift_width = input_width + man_width;

    // Stage 1 registers
    logic                          s1_valid;
    logic                          s1_sign;
    logic [input_width-1:0]        s1_magnitude;
    fp_convert_pkg::fixed_format_t s1_format;

    // Stage 2 registers
    logic                          s2_valid;
    logic                          s2_sign;
    logic [input_width-1:0]        s2_magnitude;
    fp_convert_pkg::fixed_format_t s2_format;
    logic [index_width-1:0]        s2_index;

    // Stage 3 combinational terms
    logic [index_width-1:0]        msb_index;
    logic                          round_up;
    logic [shift_width-1:0]        aligned;
    int                            exponent_value;
    logic [exp_width-1:0]          exponent_base;
    logic [exp_width-1:0]          exponent_final;
    logic [man_width:0]            mantissa_rounded;
    logic [man_width-1:0]          mantissa_final;
    logic [fp_convert_pkg::float_width-1:0] packed_word;

    // --------------------
    // Valid bits
    // --------------------

    // Bubbles travel as valid = 0, everything freezes while advance is low
    always_ff @(posedge clock) begin
        if (!reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    // --------------------
    // Stage 1: sign + abs
    // --------------------

    // Magnitude is unsigned so the most negative input keeps its full value
    always_ff @(posedge clock) begin
        if (advance) begin
            s1_sign      <= in_data[input_width-1];
            s1_magnitude <= in_data[input_width-1] ? (~in_data + 1'b1) : in_data;
            s1_format    <= in_format;
        end
    end

    // --------------------
    // Stage 2: leading one
    // --------------------

    leading_one_detector #(
        .input_width(input_width)
    ) i_lod (
        .magnitude(s1_magnitude),
        .msb_index(msb_index)
    );

    always_ff @(posedge clock) begin
        if (advance) begin
            s2_sign      <= s1_sign;
            s2_magnitude <= s1_magnitude;
            s2_format    <= s1_format;
            s2_index     <= msb_index;
        end
    end

    // --------------------
    // Stage 3: pack
    // --------------------

    rounding_engine #(
        .input_width(input_width)
    ) i_rounder (
        .magnitude(s2_magnitude),
        .msb_index(s2_index),
        .round_up(round_up)
    );

    // Put the leading one at bit 23 so the fraction sits in the low bits
    always_comb begin
        if (int'(s2_index) < man_width) begin
            aligned = shift_width'(s2_magnitude) << (man_width - int'(s2_index));
        end else begin
            aligned = shift_width'(s2_magnitude) >> (int'(s2_index) - man_width);
        end
    end

    // Q inputs are scaled down by 2^(input_width-1)
    always_comb begin
        exponent_value = fp_convert_pkg::exponent_bias + int'(s2_index);
        if (s2_format == fp_convert_pkg::fmt_q) begin
            exponent_value = exponent_value - (input_width - 1);
        end
        exponent_base = exp_width'(exponent_value);
    end

    assign mantissa_rounded = {1'b0, aligned[man_width-1:0]} + (man_width + 1)'(round_up);

    // Carry out of the mantissa bumps the exponent by one
    always_comb begin
        if (mantissa_rounded[man_width]) begin
            mantissa_final = '0;
            exponent_final = exponent_base + 1'b1;
        end else begin
            mantissa_final = mantissa_rounded[man_width-1:0];
            exponent_final = exponent_base;
        end
        if (s2_magnitude == '0) begin
            packed_word = '0;
        end else begin
            packed_word = {s2_sign, exponent_final, mantissa_final};
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            out_data <= packed_word;
        end
    end

    // --------------------
    // Assertions
    // --------------------

    out_valid_cleared_by_reset: assert property (
        @(posedge clock) !reset |=> !out_valid
    );

    // Back-pressure must hold every stage, not just the output
    valid_bits_hold_when_stalled: assert property (
        @(posedge clock) disable iff (!reset)
        !advance |=> $stable({s1_valid, s2_valid, out_valid})
    );

    // Integer inputs can never reach the reserved exponent codes
    exponent_in_normal_range: assert property (
        @(posedge clock) disable iff (!reset)
        (out_valid && out_data != '0) |->
            (out_data[30:23] != 8'h00 && out_data[30:23] != 8'hff)
    );

endmodule

//--- src/fp_convert_pkg.sv
// Shared float field widths and format tags; output is IEEE-754 single precision only

package fp_convert_pkg;

    // --------------------
    // Output float layout
    // --------------------

    // Total width of the packed float word
    localparam int float_width = 32;

    // Stored mantissa bits, hidden one not included
    localparam int mantissa_width = 23;

    // Biased exponent field
    localparam int exponent_width = 8;
    localparam int exponent_bias = 127;

    // --------------------
    // Stream sideband
    // --------------------

    // Routing tag carried next to each sample
    localparam int dest_width = 8;

    // Register stages between input and output of the converter
    // The sideband delay line uses the same count to stay aligned
    localparam int pipeline_depth = 3;

    // --------------------
    // Input formats
    // --------------------

    // fmt_integer reads the raw word as a plain integer
    // fmt_q puts the binary point just below the sign bit
    typedef enum logic {
        fmt_integer = 1'b0,
        fmt_q       = 1'b1
    } fixed_format_t;

endpackage

//--- src/fp_convert_top.sv
// Latency is three enabled cycles; in_ready follows out_ready combinationally with no skid buffer
`timescale 1ns/10ps

module fp_convert_top #(
    parameter int input_width = 32
) (
    input  logic                                  clock,
    input  logic                                  reset,

    // Sample input stream
    input  logic                                  in_valid,
    input  logic [input_width-1:0]                in_data,
    input  fp_convert_pkg::fixed_format_t         in_format,
    input  logic [fp_convert_pkg::dest_width-1:0] in_dest,
    input  logic                                  in_last,
    output logic                                  in_ready,

    // Float output stream
    output logic                                  out_valid,
    output logic [fp_convert_pkg::float_width-1:0] out_data,
    output logic [fp_convert_pkg::dest_width-1:0] out_dest,
    output logic                                  out_last,
    input  logic                                  out_ready
);

    // Whole pipeline steps together whenever the consumer can take data
    logic advance;

    // --------------------
    // Ready path
    // --------------------

    assign advance  = out_ready;
    assign in_ready = out_ready;

    // --------------------
    // Data path
    // --------------------

    fixed_to_float #(
        .input_width(input_width)
    ) i_converter (
        .clock(clock),
        .reset(reset),
        .advance(advance),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_format(in_format),
        .out_valid(out_valid),
        .out_data(out_data)
    );

    // --------------------
    // Sideband path
    // --------------------

    // Same depth and same enable as the converter so tags stay with their sample
    sideband_delay i_sideband (
        .clock(clock),
        .reset(reset),
        .advance(advance),
        .in_dest(in_dest),
        .in_last(in_last),
        .out_dest(out_dest),
        .out_last(out_last)
    );

endmodule

//--- src/leading_one_detector.sv
// Purely combinational; a zero magnitude returns index 0, so the caller must detect zero itself
`timescale 1ns/10ps

module leading_one_detector #(
    parameter int input_width = 32
) (
    input  logic [input_width-1:0]         magnitude,
    output logic [$clog2(input_width)-1:0] msb_index
);

    localparam int index_width = $clog2(input_width);

    // --------------------
    // Priority encoder
    // --------------------

    // Scan from the bottom up so the highest set bit wins
    always_comb begin
        msb_index = '0;
        for (int i = 0; i < input_width; i++) begin
            if (magnitude[i]) begin
                msb_index = index_width'(i);
            end
        end
    end

endmodule

//--- src/rounding_engine.sv
// Round-to-nearest-even decision only; rounds solely when the leading one sits above bit 23
`timescale 1ns/10ps

module rounding_engine #(
    parameter int input_width = 32
) (
    input  logic [input_width-1:0]         magnitude,
    input  logic [$clog2(input_width)-1:0] msb_index,
    output logic                           round_up
);

    // Number of magnitude bits that fall below the kept mantissa
    int drop_count;

    logic guard_bit;
    logic sticky_bit;
    logic kept_lsb;

    assign drop_count = int'(msb_index) - fp_convert_pkg::mantissa_width;

    // --------------------
    // Guard, sticky, lsb
    // --------------------

    // Guard is the highest dropped bit, sticky ORs everything under it
    always_comb begin
        guard_bit  = 1'b0;
        sticky_bit = 1'b0;
        kept_lsb   = 1'b0;
        if (drop_count > 0) begin
            for (int i = 0; i < input_width; i++) begin
                if (i == drop_count) begin
                    kept_lsb = magnitude[i];
                end
                if (i == drop_count - 1) begin
                    guard_bit = magnitude[i];
                end
                if (i < drop_count - 1) begin
                    sticky_bit = sticky_bit | magnitude[i];
                end
            end
        end
    end

    // Above half rounds up, exact half goes to the even neighbour
    assign round_up = guard_bit & (sticky_bit | kept_lsb);

endmodule

//--- src/sideband_delay.sv
// Depth is fixed by the package pipeline depth; moves only on advance to stay aligned with data
`timescale 1ns/10ps

module sideband_delay (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 advance,
    input  logic [fp_convert_pkg::dest_width-1:0] in_dest,
    input  logic                                 in_last,
    output logic [fp_convert_pkg::dest_width-1:0] out_dest,
    output logic                                 out_last
);

    localparam int depth = fp_convert_pkg::pipeline_depth;

    logic [fp_convert_pkg::dest_width-1:0] dest_stage [depth];
    logic [depth-1:0]                      last_stage;

    // --------------------
    // Shift register
    // --------------------

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < depth; i++) begin
                dest_stage[i] <= '0;
            end
            last_stage <= '0;
        end else if (advance) begin
            dest_stage[0] <= in_dest;
            for (int i = 1; i < depth; i++) begin
                dest_stage[i] <= dest_stage[i-1];
            end
            last_stage <= {last_stage[depth-2:0], in_last};
        end
    end

    assign out_dest = dest_stage[depth-1];
    assign out_last = last_stage[depth-1];

    // A stale tlast after reset would close a packet that never started
    out_last_cleared_by_reset: assert property (
        @(posedge clock) !reset |=> !out_last
    );

endmodule

//--- tb.f
+incdir+verification
src/fp_convert_pkg.sv
src/leading_one_detector.sv
src/rounding_engine.sv
src/fixed_to_float.sv
src/sideband_delay.sv
src/fp_convert_top.sv
verification/tb_clock_gen.sv
verification/fp_convert_tb.sv

//--- verification/float_model.svh
// Reference model assumes inputs of at most 32 bits and relies on 64-bit integer arithmetic
`ifndef float_model_svh
`define float_model_svh

// --------------------
// Galois LFSR
// --------------------

// 16-bit right-shifting form with taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_advance(input logic [15:0] state);
    logic [15:0] next_state;
    next_state = state >> 1;
    if (state[0]) begin
        next_state = next_state ^ 16'hb400;
    end
    return next_state;
endfunction

// --------------------
// Fixed to float
// --------------------

// Exact integer conversion, remainder compared against half for round half to even
function automatic logic [31:0] fixed_to_single(input logic [31:0] raw, input bit is_q,
                                                input int width);
    longint raw_value;
    longint magnitude;
    longint kept;
    longint remainder;
    longint half;
    int     top_bit;
    int     shift;
    int     exponent;
    logic   sign;
    raw_value = longint'(raw) & ((longint'(1) << width) - 1);
    sign = raw[width-1];
    magnitude = sign ? (longint'(1) << width) - raw_value : raw_value;
    if (magnitude == 0) begin
        return 32'h0;
    end
    top_bit = 0;
    for (int i = 0; i < 63; i++) begin
        if (((magnitude >> i) & 1) == 1) begin
            top_bit = i;
        end
    end
    if (top_bit <= 23) begin
        kept = magnitude << (23 - top_bit);
    end else begin
        shift = top_bit - 23;
        kept = magnitude >> shift;
        remainder = magnitude - (kept << shift);
        half = longint'(1) << (shift - 1);
        if (remainder > half || (remainder == half && (kept % 2) == 1)) begin
            kept = kept + 1;
        end
        // Rounding past 2^24 moves the leading one up by one place
        if (kept == (longint'(1) << 24)) begin
            kept = kept >> 1;
            top_bit = top_bit + 1;
        end
    end
    exponent = fp_convert_pkg::exponent_bias + top_bit - (is_q ? width - 1 : 0);
    return {sign, exponent[7:0], kept[22:0]};
endfunction

`endif

//--- verification/fp_convert_tb.sv
// Runs the DUT with 32-bit inputs; every check is a concurrent assertion on the output stream
`timescale 1ns/10ps

module fp_convert_tb;

    localparam int data_width = 32;
    localparam int accept_limit = 64;
    localparam int drain_limit = 200;
    localparam int reset_limit = 20;
    localparam int random_count = 400;

    logic                                   clock;
    logic                                   reset;
    logic                                   in_valid;
    logic [data_width-1:0]                  in_data;
    fp_convert_pkg::fixed_format_t          in_format;
    logic [fp_convert_pkg::dest_width-1:0]  in_dest;
    logic                                   in_last;
    logic                                   in_ready;
    logic                                   out_valid;
    logic [fp_convert_pkg::float_width-1:0] out_data;
    logic [fp_convert_pkg::dest_width-1:0]  out_dest;
    logic                                   out_last;
    logic                                   out_ready;

    // Each accepted sample queues its float word then dest then last
    logic [31:0]                            expected_q [$];
    int                                     pending_count = 0;
    logic [31:0]                            pending_data;
    logic [fp_convert_pkg::dest_width-1:0]  pending_dest;
    logic                                   pending_last;

    // Output values one edge back for the stall checks
    logic                                   stalled_prev = 1'b0;
    logic                                   prev_valid;
    logic [31:0]                            prev_data;
    logic [fp_convert_pkg::dest_width-1:0]  prev_dest;
    logic                                   prev_last;

    int                                     cycle_count = 0;
    int                                     accept_cycle = 0;
    int                                     consume_cycle = 0;
    logic [15:0]                            lfsr_state = 16'd36851;

    `include "float_model.svh"

    tb_clock_gen i_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    fp_convert_top #(
        .input_width(data_width)
    ) i_dut (
        .clock(clock),
        .reset(reset),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_format(in_format),
        .in_dest(in_dest),
        .in_last(in_last),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_dest(out_dest),
        .out_last(out_last),
        .out_ready(out_ready)
    );

    task automatic report_failure(input string message);
        $display("%s", message);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_advance(lfsr_state);
        end
        return value;
    endfunction

    // Consumer is ready about three cycles in four
    function automatic logic pick_ready();
        return random_bits(2) != 0;
    endfunction

    // --------------------
    // Scoreboard
    // --------------------

    always @(posedge clock) begin
        if (!reset) begin
            expected_q.delete();
            stalled_prev <= 1'b0;
        end else begin
            if (out_valid && out_ready && expected_q.size() >= 3) begin
                void'(expected_q.pop_front());
                void'(expected_q.pop_front());
                void'(expected_q.pop_front());
                consume_cycle = cycle_count;
            end
            if (in_valid && in_ready) begin
                expected_q.push_back(fixed_to_single(in_data,
                                     in_format == fp_convert_pkg::fmt_q, data_width));
                expected_q.push_back(32'(in_dest));
                expected_q.push_back(32'(in_last));
                accept_cycle = cycle_count;
            end
            stalled_prev <= out_valid && !out_ready;
        end
        cycle_count = cycle_count + 1;
        pending_count = expected_q.size() / 3;
        if (pending_count > 0) begin
            pending_data = expected_q[0];
            pending_dest = fp_convert_pkg::dest_width'(expected_q[1]);
            pending_last = expected_q[2] != 0;
        end
        prev_valid <= out_valid;
        prev_data  <= out_data;
        prev_dest  <= out_dest;
        prev_last  <= out_last;
    end

    // --------------------
    // Checks
    // --------------------

    ready_follows_out_ready: assert property (@(posedge clock) in_ready == out_ready)
        else report_failure($sformatf("[FAIL] in_ready expected %h actual %h",
                                      $sampled(out_ready), $sampled(in_ready)));

    reset_clears_valid: assert property (@(posedge clock) !reset |=> !out_valid)
        else report_failure($sformatf("[FAIL] out_valid expected 0 actual %h",
                                      $sampled(out_valid)));

    reset_clears_dest: assert property (@(posedge clock) !reset |=> out_dest == '0)
        else report_failure($sformatf("[FAIL] out_dest expected 00 actual %h",
                                      $sampled(out_dest)));

    reset_clears_last: assert property (@(posedge clock) !reset |=> !out_last)
        else report_failure($sformatf("[FAIL] out_last expected 0 actual %h",
                                      $sampled(out_last)));

    output_was_expected: assert property (@(posedge clock) disable iff (!reset)
        (out_valid && out_ready) |-> pending_count > 0)
        else report_failure("DUT delivered an output while no sample was pending");

    data_matches: assert property (@(posedge clock) disable iff (!reset)
        (out_valid && out_ready && pending_count > 0) |-> out_data == pending_data)
        else report_failure($sformatf("[FAIL] out_data expected %h actual %h",
                                      $sampled(pending_data), $sampled(out_data)));

    dest_matches: assert property (@(posedge clock) disable iff (!reset)
        (out_valid && out_ready && pending_count > 0) |-> out_dest == pending_dest)
        else report_failure($sformatf("[FAIL] out_dest expected %h actual %h",
                                      $sampled(pending_dest), $sampled(out_dest)));

    last_matches: assert property (@(posedge clock) disable iff (!reset)
        (out_valid && out_ready && pending_count > 0) |-> out_last == pending_last)
        else report_failure($sformatf("[FAIL] out_last expected %h actual %h",
                                      $sampled(pending_last), $sampled(out_last)));

    // Outputs must not move across an edge where out_ready was low
    valid_holds: assert property (@(posedge clock) disable iff (!reset)
        stalled_prev |-> out_valid == prev_valid)
        else report_failure($sformatf("[FAIL] out_valid expected %h actual %h",
                                      $sampled(prev_valid), $sampled(out_valid)));

    data_holds: assert property (@(posedge clock) disable iff (!reset)
        stalled_prev |-> out_data == prev_data)
        else report_failure($sformatf("[FAIL] out_data expected %h actual %h",
                                      $sampled(prev_data), $sampled(out_data)));

    dest_holds: assert property (@(posedge clock) disable iff (!reset)
        stalled_prev |-> out_dest == prev_dest)
        else report_failure($sformatf("[FAIL] out_dest expected %h actual %h",
                                      $sampled(prev_dest), $sampled(out_dest)));

    last_holds: assert property (@(posedge clock) disable iff (!reset)
        stalled_prev |-> out_last == prev_last)
        else report_failure($sformatf("[FAIL] out_last expected %h actual %h",
                                      $sampled(prev_last), $sampled(out_last)));

    latency_is_three: assert property (@(posedge clock) disable iff (!reset)
        (in_valid && in_ready) ##1 out_ready [*2] |=> out_valid)
        else report_failure("out_valid did not rise three enabled cycles after acceptance");

    // --------------------
    // Stimulus
    // --------------------

    task automatic drive_cycle(input logic valid, input logic [31:0] data,
                               input fp_convert_pkg::fixed_format_t format,
                               input logic [7:0] dest, input logic last,
                               input logic ready, output logic accepted);
        in_valid  = valid;
        in_data   = data;
        in_format = format;
        in_dest   = dest;
        in_last   = last;
        out_ready = ready;
        @(posedge clock);
        accepted = in_valid && in_ready;
        #1;
    endtask

    task automatic idle_cycle(input bit random_ready);
        logic ready;
        logic accepted;
        ready = random_ready ? pick_ready() : 1'b1;
        drive_cycle(1'b0, '0, fp_convert_pkg::fmt_integer, '0, 1'b0, ready, accepted);
    endtask

    task automatic send_sample(input logic [31:0] data, input fp_convert_pkg::fixed_format_t format,
                               input logic [7:0] dest, input logic last, input bit random_ready);
        int   tries;
        logic ready;
        logic accepted;
        tries = 0;
        accepted = 1'b0;
        while (!accepted && tries < accept_limit) begin
            ready = random_ready ? pick_ready() : 1'b1;
            drive_cycle(1'b1, data, format, dest, last, ready, accepted);
            tries++;
        end
        if (!accepted) begin
            report_failure("input sample was never accepted before the timeout");
        end
    endtask

    task automatic drain_outputs();
        int tries;
        tries = 0;
        while (pending_count != 0 && tries < drain_limit) begin
            idle_cycle(1'b0);
            tries++;
        end
        if (pending_count != 0) begin
            report_failure("expected output never arrived before the timeout");
        end
    endtask

    task automatic check_model(input logic [31:0] raw, input bit is_q, input logic [31:0] expected);
        logic [31:0] result;
        result = fixed_to_single(raw, is_q, data_width);
        assert (result == expected)
            else report_failure($sformatf("reference model gives %h for %h, wanted %h",
                                          result, raw, expected));
    endtask

    initial begin
        int          waited;
        logic [31:0] sample;
        logic        format_bit;
        logic [7:0]  dest;
        logic        last;
        in_valid  = 1'b0;
        in_data   = '0;
        in_format = fp_convert_pkg::fmt_integer;
        in_dest   = '0;
        in_last   = 1'b0;
        out_ready = 1'b0;

        check_model(32'd1, 1'b0, 32'h3f80_0000);
        check_model(32'd1, 1'b1, 32'h3000_0000);
        check_model(32'hffff_ffff, 1'b0, 32'hbf80_0000);
        check_model(32'h8000_0000, 1'b0, 32'hcf00_0000);
        check_model(32'd16777217, 1'b0, 32'h4b80_0000);
        check_model(32'd16777219, 1'b0, 32'h4b80_0002);
        check_model(32'd2147483647, 1'b0, 32'h4f00_0000);

        waited = 0;
        while (reset !== 1'b1 && waited < reset_limit) begin
            @(posedge clock);
            waited++;
        end
        if (reset !== 1'b1) begin
            report_failure("reset was never released");
        end
        #1;

        // Directed values, zeros and rounding corners
        send_sample(32'd1, fp_convert_pkg::fmt_integer, 8'h01, 1'b0, 1'b0);
        send_sample(32'd1, fp_convert_pkg::fmt_q, 8'h02, 1'b0, 1'b0);
        send_sample(32'hffff_ffff, fp_convert_pkg::fmt_integer, 8'h03, 1'b0, 1'b0);
        send_sample(32'h8000_0000, fp_convert_pkg::fmt_integer, 8'h04, 1'b1, 1'b0);
        send_sample(32'h8000_0000, fp_convert_pkg::fmt_q, 8'h05, 1'b0, 1'b0);
        send_sample(32'd0, fp_convert_pkg::fmt_integer, 8'h06, 1'b0, 1'b0);
        send_sample(32'd0, fp_convert_pkg::fmt_q, 8'h07, 1'b1, 1'b0);
        send_sample(32'd16777217, fp_convert_pkg::fmt_integer, 8'h08, 1'b0, 1'b0);
        send_sample(32'd16777219, fp_convert_pkg::fmt_integer, 8'h09, 1'b0, 1'b0);
        send_sample(32'd2147483647, fp_convert_pkg::fmt_integer, 8'h0a, 1'b0, 1'b0);
        send_sample(32'd2147483647, fp_convert_pkg::fmt_q, 8'h0b, 1'b1, 1'b0);
        drain_outputs();

        // Lone sample with out_ready held high
        idle_cycle(1'b0);
        send_sample(32'h0001_2345, fp_convert_pkg::fmt_integer, 8'h5a, 1'b1, 1'b0);
        drain_outputs();
        assert (consume_cycle - accept_cycle == 3)
            else report_failure($sformatf("lone sample took %0d cycles instead of 3",
                                          consume_cycle - accept_cycle));

        // Random samples with valid gaps and back-pressure
        for (int n = 0; n < random_count; n++) begin
            if (random_bits(2) == 0) begin
                idle_cycle(1'b1);
            end
            sample = random_bits(32);
            sample = $signed(sample) >>> random_bits(5);
            format_bit = 1'(random_bits(1));
            dest = 8'(random_bits(8));
            last = random_bits(3) == 0;
            send_sample(sample, fp_convert_pkg::fixed_format_t'(format_bit), dest, last, 1'b1);
        end
        drain_outputs();

        if (expected_q.size() != 0) begin
            report_failure("expected queue still holds entries at the end of the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- verification/tb_clock_gen.sv
// Free-running 10 ns clock; reset is held low for four rising edges and released 1 ns after the fourth
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // Release lines up with the testbench drive point after the edge
    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clock);
        #1 reset = 1'b1;
    end

endmodule
